// File: hw/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Datapath widths
`define DATA_W 32
`define REG_W 5

// ISA build selection, 1 builds the ISA in and 0 leaves it out.
// With both at 1 the core is combined and armD picks the mode per instruction.
`define ENABLE_RISCV 1
`define ENABLE_ARM 1

`endif

// File: hw/execPkg.sv
`default_nettype none

package execPkg;

  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluSub  = 4'd1,
    aluAnd  = 4'd2,
    aluOr   = 4'd3,
    aluXor  = 4'd4,
    aluSlt  = 4'd5,  // Signed compare, result is 0 or 1
    aluSltu = 4'd6,
    aluSll  = 4'd7,
    aluSrl  = 4'd8,
    aluSra  = 4'd9
  } aluOpT;

  typedef enum logic [1:0] {
    fwdRf  = 2'b00,  // Value read in decode
    fwdWb  = 2'b01,
    fwdMem = 2'b10
  } fwdSelT;

  typedef enum logic [1:0] {
    resAlu = 2'b00,
    resMem = 2'b01,
    resPc4 = 2'b10   // Link value for jumps
  } resultSrcT;

  // ARM condition field encodings
  typedef enum logic [3:0] {
    condEq = 4'd0,  condNe = 4'd1,  condCs = 4'd2,  condCc = 4'd3,
    condMi = 4'd4,  condPl = 4'd5,  condVs = 4'd6,  condVc = 4'd7,
    condHi = 4'd8,  condLs = 4'd9,  condGe = 4'd10, condLt = 4'd11,
    condGt = 4'd12, condLe = 4'd13, condAl = 4'd14
  } condT;

  localparam int flagIdxN = 3;
  localparam int flagIdxZ = 2;
  localparam int flagIdxC = 1;
  localparam int flagIdxV = 0;

endpackage

`default_nettype wire

// File: hw/execAlu.sv
`timescale 1ns/100ps
`default_nettype none
`include "exec_cfg.svh"

module execAlu
  import execPkg::*;
(
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  aluOpT              aluOp,
  output logic [`DATA_W-1:0] result,
  output logic [3:0]         aluFlags
);

  localparam int ShW = $clog2(`DATA_W);

  logic               subtract;
  logic               arith;
  logic [`DATA_W-1:0] bOp;
  logic [`DATA_W:0]   sum;
  logic               carry;
  logic               overflow;
  logic [ShW-1:0]     shamt;

  // One adder serves add, sub and both compares
  assign subtract = (aluOp == aluSub) || (aluOp == aluSlt) || (aluOp == aluSltu);
  assign arith    = subtract || (aluOp == aluAdd);
  assign bOp      = subtract ? ~b : b;
  assign sum      = {1'b0, a} + {1'b0, bOp} + {{`DATA_W{1'b0}}, subtract};
  assign carry    = sum[`DATA_W];  // High means no borrow on subtract
  assign overflow = (a[`DATA_W-1] == bOp[`DATA_W-1]) &&
                    (sum[`DATA_W-1] != a[`DATA_W-1]);
  assign shamt    = b[ShW-1:0];

  always_comb begin
    case (aluOp)
      aluAdd,
      aluSub:  result = sum[`DATA_W-1:0];
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluXor:  result = a ^ b;
      aluSlt:  result = {{(`DATA_W-1){1'b0}}, sum[`DATA_W-1] ^ overflow};
      aluSltu: result = {{(`DATA_W-1){1'b0}}, ~carry};
      aluSll:  result = a << shamt;
      aluSrl:  result = a >> shamt;
      aluSra:  result = $unsigned($signed(a) >>> shamt);
      default: result = '0;
    endcase
  end

  assign aluFlags[flagIdxN] = result[`DATA_W-1];
  assign aluFlags[flagIdxZ] = (result == '0);
  assign aluFlags[flagIdxC] = arith & carry;  // Logic and shifts give zero
  assign aluFlags[flagIdxV] = arith & overflow;

endmodule

`default_nettype wire

// File: hw/execCondLogic.sv
`timescale 1ns/100ps
`default_nettype none

module execCondLogic
  import execPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  condT       condE,
  input  logic [1:0] flagWriteE,
  input  logic [3:0] aluFlags,
  input  logic       regWriteIn,
  input  logic       memWriteIn,
  input  logic       pcSrcIn,
  output logic       regWriteOut,
  output logic       memWriteOut,
  output logic       pcSrcOut
);

  logic [3:0] flags;
  logic       condEx;
  logic       n;
  logic       z;
  logic       c;
  logic       v;

  assign n = flags[flagIdxN];
  assign z = flags[flagIdxZ];
  assign c = flags[flagIdxC];
  assign v = flags[flagIdxV];

  // Condition is judged on flags left by older instructions
  always_comb begin
    case (condE)
      condEq:  condEx = z;
      condNe:  condEx = ~z;
      condCs:  condEx = c;
      condCc:  condEx = ~c;
      condMi:  condEx = n;
      condPl:  condEx = ~n;
      condVs:  condEx = v;
      condVc:  condEx = ~v;
      condHi:  condEx = c & ~z;
      condLs:  condEx = ~c | z;
      condGe:  condEx = (n == v);
      condLt:  condEx = (n != v);
      condGt:  condEx = ~z & (n == v);
      condLe:  condEx = z | (n != v);
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;
    endcase
  end

  assign regWriteOut = regWriteIn & condEx;
  assign memWriteOut = memWriteIn & condEx;
  assign pcSrcOut    = pcSrcIn & condEx;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= 4'b0000;
    end else if (condEx) begin
      if (flagWriteE[1]) begin  // N and Z
        flags[flagIdxN] <= aluFlags[flagIdxN];
        flags[flagIdxZ] <= aluFlags[flagIdxZ];
      end
      if (flagWriteE[0]) begin  // C and V
        flags[flagIdxC] <= aluFlags[flagIdxC];
        flags[flagIdxV] <= aluFlags[flagIdxV];
      end
    end
  end

  // A failed flag-setting instruction leaves later conditions as they were
  flagsHeldOnFail: assert property (@(posedge clk) disable iff (!arstN)
    (!condEx && (flagWriteE != 2'b00)) |=> $stable(flags))
    else $error("flags changed under a failing condition");

endmodule

`default_nettype wire

// File: hw/execOperandSelect.sv
`timescale 1ns/100ps
`default_nettype none
`include "exec_cfg.svh"

module execOperandSelect
  import execPkg::*;
(
  input  logic [`DATA_W-1:0] rd1E,
  input  logic [`DATA_W-1:0] rd2E,
  input  logic [`DATA_W-1:0] immExtE,
  input  logic [`DATA_W-1:0] pcE,
  input  logic [`DATA_W-1:0] resultW,
  input  logic [`DATA_W-1:0] aluResultM,
  input  fwdSelT             forwardAE,
  input  fwdSelT             forwardBE,
  input  logic               aluSrcE,
  output logic [`DATA_W-1:0] srcA,
  output logic [`DATA_W-1:0] srcB,
  output logic [`DATA_W-1:0] writeDataE,
  output logic [`DATA_W-1:0] pcTargetE
);

  function automatic logic [`DATA_W-1:0] fwdMux(input fwdSelT sel,
                                                input logic [`DATA_W-1:0] regVal,
                                                input logic [`DATA_W-1:0] wbVal,
                                                input logic [`DATA_W-1:0] memVal);
    case (sel)
      fwdWb:   return wbVal;
      fwdMem:  return memVal;
      default: return regVal;
    endcase
  endfunction

  assign srcA       = fwdMux(forwardAE, rd1E, resultW, aluResultM);
  assign writeDataE = fwdMux(forwardBE, rd2E, resultW, aluResultM);  // Store data too
  assign srcB       = aluSrcE ? immExtE : writeDataE;

  // jalr style targets take the register base
  assign pcTargetE  = (aluSrcE ? srcA : pcE) + immExtE;

endmodule

`default_nettype wire

// File: hw/execStage.sv
`timescale 1ns/100ps
`default_nettype none
`include "exec_cfg.svh"

module execStage
  import execPkg::*;
(
  input  logic               clk,
  input  logic               arstN,
  input  logic               flushE,
  input  logic [`DATA_W-1:0] rd1D, rd2D,
  input  logic [`DATA_W-1:0] immExtD,
  input  logic [`DATA_W-1:0] pcD, pcPlus4D,
  input  logic [`REG_W-1:0]  rdD, rs1D, rs2D,
  input  logic               armD,  // Used by the combined build only
  input  logic               regWriteD, memWriteD, aluSrcD,
  input  logic [1:0]         branchD,
  input  aluOpT              aluControlD,
  input  logic               pcSrcD,
  input  logic [1:0]         flagWriteD,
  input  condT               condD,
  input  resultSrcT          resultSrcD,
  input  logic [1:0]         memSizeD,
  input  logic               memSignedD,
  input  fwdSelT             forwardAE, forwardBE,
  input  logic [`DATA_W-1:0] aluResultM, resultW,
  output logic [`DATA_W-1:0] aluResultE, writeDataE,
  output logic [`REG_W-1:0]  rdE,
  output logic               regWriteE, memWriteE,
  output logic [1:0]         branchTakenE,
  output logic [`DATA_W-1:0] pcTargetE, pcPlus4E,
  output resultSrcT          resultSrcE,
  output logic [`REG_W-1:0]  rs1E, rs2E,
  output logic [1:0]         memSizeE,
  output logic               memSignedE,
  output logic               armE
);

  logic [`DATA_W-1:0] rd1E, rd2E, immExtE, pcE, pcPlus4Raw;
  logic               regWriteRaw, memWriteRaw, aluSrcE, pcSrcE;
  logic [1:0]         branchE;
  logic [1:0]         flagWriteE;
  aluOpT              aluControlE;
  condT               condE;
  logic [`DATA_W-1:0] srcA, srcB;
  logic [3:0]         aluFlags;
  logic               regWriteArm, memWriteArm;
  logic               pcChangeReq, pcChangeArm;
  logic               cmpBit;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {rd1E, rd2E, immExtE, pcE, pcPlus4Raw} <= '0;
      {rdE, rs1E, rs2E} <= '0;
      {regWriteRaw, memWriteRaw, aluSrcE, pcSrcE} <= 4'b0000;
      branchE     <= 2'b00;
      flagWriteE  <= 2'b00;
      aluControlE <= aluAdd;
      condE       <= condAl;
      resultSrcE  <= resAlu;
      memSizeE    <= 2'b00;
      memSignedE  <= 1'b0;
    end else begin
      {rd1E, rd2E, immExtE, pcE, pcPlus4Raw} <= {rd1D, rd2D, immExtD, pcD, pcPlus4D};
      {rdE, rs1E, rs2E} <= {rdD, rs1D, rs2D};
      aluSrcE     <= aluSrcD;
      aluControlE <= aluControlD;
      condE       <= condD;
      resultSrcE  <= resultSrcD;
      memSizeE    <= memSizeD;    // Carried for the memory stage
      memSignedE  <= memSignedD;
      if (flushE) begin  // Turns the slot into a bubble
        {regWriteRaw, memWriteRaw, pcSrcE} <= 3'b000;
        branchE    <= 2'b00;
        flagWriteE <= 2'b00;
      end else begin
        {regWriteRaw, memWriteRaw, pcSrcE} <= {regWriteD, memWriteD, pcSrcD};
        branchE    <= branchD;
        flagWriteE <= flagWriteD;
      end
    end
  end

  generate
    if (`ENABLE_RISCV && `ENABLE_ARM) begin : gCombined
      always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) armE <= 1'b0;
        else        armE <= armD;
      end
    end else begin : gSingle
      assign armE = (`ENABLE_ARM != 0);
    end
  endgenerate

  execOperandSelect uOperands (
    .rd1E, .rd2E, .immExtE, .pcE, .resultW, .aluResultM,
    .forwardAE, .forwardBE, .aluSrcE,
    .srcA, .srcB, .writeDataE, .pcTargetE
  );

  execAlu uAlu (
    .a(srcA),
    .b(srcB),
    .aluOp(aluControlE),
    .result(aluResultE),
    .aluFlags(aluFlags)
  );

  // An ARM branch is also a PC change, so one gated bit covers both
  assign pcChangeReq = pcSrcE | branchE[1];

  execCondLogic uCond (
    .clk, .arstN, .condE, .flagWriteE, .aluFlags,
    .regWriteIn(regWriteRaw),
    .memWriteIn(memWriteRaw),
    .pcSrcIn(pcChangeReq),
    .regWriteOut(regWriteArm),
    .memWriteOut(memWriteArm),
    .pcSrcOut(pcChangeArm)
  );

  assign regWriteE = armE ? regWriteArm : regWriteRaw;
  assign memWriteE = armE ? memWriteArm : memWriteRaw;

  // RISC-V: slt ops compare on the low bit, others on zero; branchE[1] inverts
  assign cmpBit = ((aluControlE == aluSlt) || (aluControlE == aluSltu)) ?
                  aluResultE[0] : aluFlags[flagIdxZ];
  assign branchTakenE[1] = armE & branchE[1] & pcChangeArm;
  assign branchTakenE[0] = ~armE & branchE[0] &
                           ((resultSrcE == resPc4) | (cmpBit ^ branchE[1]));  // Jumps always
  assign pcPlus4E = (armE & pcChangeArm & ~branchE[1]) ? pcTargetE : pcPlus4Raw;

  flushKillsWrites: assert property (@(posedge clk) disable iff (!arstN)
    flushE |=> (!regWriteE && !memWriteE))
    else $error("write enable survived a flush");

  aluOpDefined: assert property (@(posedge clk) disable iff (!arstN)
    aluControlE inside {aluAdd, aluSub, aluAnd, aluOr, aluXor,
                        aluSlt, aluSltu, aluSll, aluSrl, aluSra})
    else $error("undefined ALU operation %0d", aluControlE);

endmodule

`default_nettype wire

// File: hw/execHazardUnit.sv
`timescale 1ns/100ps
`default_nettype none
`include "exec_cfg.svh"

module execHazardUnit
  import execPkg::*;
(
  input  logic [`REG_W-1:0] rs1E,
  input  logic [`REG_W-1:0] rs2E,
  input  logic [`REG_W-1:0] rdM,
  input  logic [`REG_W-1:0] rdW,
  input  logic              regWriteM,
  input  logic              regWriteW,
  output fwdSelT            forwardAE,
  output fwdSelT            forwardBE
);

  // Youngest producer wins, x0 never forwards
  function automatic fwdSelT pickSource(input logic [`REG_W-1:0] rs,
                                        input logic [`REG_W-1:0] rdMem,
                                        input logic              wrMem,
                                        input logic [`REG_W-1:0] rdWb,
                                        input logic              wrWb);
    if (wrMem && (rdMem != '0) && (rdMem == rs)) begin
      return fwdMem;
    end else if (wrWb && (rdWb != '0) && (rdWb == rs)) begin
      return fwdWb;
    end
    return fwdRf;
  endfunction

  assign forwardAE = pickSource(rs1E, rdM, regWriteM, rdW, regWriteW);
  assign forwardBE = pickSource(rs2E, rdM, regWriteM, rdW, regWriteW);

endmodule

`default_nettype wire

// File: hw/execRetirePipe.sv
`timescale 1ns/100ps
`default_nettype none
`include "exec_cfg.svh"

module execRetirePipe
  import execPkg::*;
(
  input  logic               clk,
  input  logic               arstN,
  input  logic [`DATA_W-1:0] aluResultE,
  input  logic [`DATA_W-1:0] pcPlus4E,
  input  logic [`REG_W-1:0]  rdE,
  input  logic               regWriteE,
  input  resultSrcT          resultSrcE,
  output logic [`DATA_W-1:0] aluResultM,
  output logic [`DATA_W-1:0] resultW,
  output logic [`REG_W-1:0]  rdM,
  output logic [`REG_W-1:0]  rdW,
  output logic               regWriteM,
  output logic               regWriteW
);

  logic [`DATA_W-1:0] pcPlus4M, aluResultW, pcPlus4W;
  resultSrcT          resultSrcM, resultSrcW;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {aluResultM, pcPlus4M, rdM, regWriteM} <= '0;
      resultSrcM <= resAlu;
      {aluResultW, pcPlus4W, rdW, regWriteW} <= '0;
      resultSrcW <= resAlu;
    end else begin
      aluResultM <= aluResultE;  // Memory stage
      pcPlus4M   <= pcPlus4E;
      rdM        <= rdE;
      regWriteM  <= regWriteE;
      resultSrcM <= resultSrcE;
      aluResultW <= aluResultM;  // Writeback stage
      pcPlus4W   <= pcPlus4M;
      rdW        <= rdM;
      regWriteW  <= regWriteM;
      resultSrcW <= resultSrcM;
    end
  end

  always_comb begin
    case (resultSrcW)
      resPc4:  resultW = pcPlus4W;
      resMem:  resultW = '0;  // No data memory behind this pipe
      default: resultW = aluResultW;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/execTop.sv
`timescale 1ns/100ps
`default_nettype none
`include "exec_cfg.svh"

module execTop
  import execPkg::*;
(
  input  logic               clk,
  input  logic               arstN,
  input  logic               flushE,
  input  logic [`DATA_W-1:0] rd1D, rd2D,
  input  logic [`DATA_W-1:0] immExtD,
  input  logic [`DATA_W-1:0] pcD, pcPlus4D,
  input  logic [`REG_W-1:0]  rdD, rs1D, rs2D,
  input  logic               armD,
  input  logic               regWriteD, memWriteD, aluSrcD,
  input  logic [1:0]         branchD,
  input  aluOpT              aluControlD,
  input  logic               pcSrcD,
  input  logic [1:0]         flagWriteD,
  input  condT               condD,
  input  resultSrcT          resultSrcD,
  input  logic [1:0]         memSizeD,
  input  logic               memSignedD,
  output logic [1:0]         branchTakenE,
  output logic [`DATA_W-1:0] pcTargetE,
  output logic               memWriteE,
  output logic [`DATA_W-1:0] writeDataE,
  output logic [`DATA_W-1:0] resultW,
  output logic [`REG_W-1:0]  rdW,
  output logic               regWriteW
);

  fwdSelT             forwardAE, forwardBE;
  logic [`DATA_W-1:0] aluResultE, pcPlus4E, aluResultM;
  logic [`REG_W-1:0]  rdE, rs1E, rs2E, rdM;
  logic               regWriteE, regWriteM;
  resultSrcT          resultSrcE;

  execStage uStage (
    .clk, .arstN, .flushE,
    .rd1D, .rd2D, .immExtD, .pcD, .pcPlus4D, .rdD, .rs1D, .rs2D, .armD,
    .regWriteD, .memWriteD, .aluSrcD, .branchD, .aluControlD, .pcSrcD,
    .flagWriteD, .condD, .resultSrcD, .memSizeD, .memSignedD,
    .forwardAE, .forwardBE, .aluResultM, .resultW,
    .aluResultE, .writeDataE, .rdE, .regWriteE, .memWriteE,
    .branchTakenE, .pcTargetE, .pcPlus4E, .resultSrcE, .rs1E, .rs2E,
    .memSizeE(),    // No memory stage consumer yet
    .memSignedE(),
    .armE()
  );

  execHazardUnit uHazard (
    .rs1E, .rs2E, .rdM, .rdW, .regWriteM, .regWriteW,
    .forwardAE, .forwardBE
  );

  execRetirePipe uRetire (
    .clk, .arstN,
    .aluResultE, .pcPlus4E, .rdE, .regWriteE, .resultSrcE,
    .aluResultM, .resultW, .rdM, .rdW, .regWriteM, .regWriteW
  );

endmodule

`default_nettype wire

// File: dv/execTbVectors.svh
`ifndef EXEC_TB_VECTORS_SVH
`define EXEC_TB_VECTORS_SVH

// Columns: name, arm, op, rd, rs1, rs2, rd1 and rd2 as the register file gives them,
// immediate, control flags, condition, expected regWriteW, expected branchTakenE
task automatic loadRows();
  addRow("addi_x1",   0, aluAdd,  1,  0,  0,  0,  0,  10,  RW | AS, condAl, 1, 2'b00);
  addRow("addi_x2",   0, aluAdd,  2,  0,  0,  0,  0,  3,   RW | AS, condAl, 1, 2'b00);
  addRow("sub_fwd",   0, aluSub,  3,  1,  2,  0,  0,  0,   RW, condAl, 1, 2'b00);  // Wb and mem
  addRow("and_fwd",   0, aluAnd,  4,  3,  1,  0,  10, 0,   RW, condAl, 1, 2'b00);
  addRow("or_fwd",    0, aluOr,   5,  4,  2,  99, 3,  0,   RW, condAl, 1, 2'b00);
  addRow("xor_fwd",   0, aluXor,  6,  5,  3,  0,  7,  0,   RW, condAl, 1, 2'b00);
  addRow("slt_fwd",   0, aluSlt,  7,  2,  6,  3,  0,  0,   RW, condAl, 1, 2'b00);
  addRow("sltu_imm",  0, aluSltu, 8,  3,  0,  7,  0,  -1,  RW | AS, condAl, 1, 2'b00);
  addRow("sll_imm",   0, aluSll,  9,  1,  0,  10, 0,  4,   RW | AS, condAl, 1, 2'b00);
  addRow("srl_fwd",   0, aluSrl,  10, 9,  0,  0,  0,  2,   RW | AS, condAl, 1, 2'b00);
  addRow("sub_neg",   0, aluSub,  11, 0,  1,  0,  10, 0,   RW, condAl, 1, 2'b00);
  addRow("sra_fwd",   0, aluSra,  12, 11, 0,  0,  0,  1,   RW | AS, condAl, 1, 2'b00);
  addRow("flushed",   0, aluAdd,  13, 1,  0,  10, 0,  5,   RW | AS | MW | FL, condAl, 0, 2'b00);
  addRow("after_fl",  0, aluAdd,  14, 13, 0,  0,  0,  0,   RW | AS, condAl, 1, 2'b00);
  addRow("write_x0",  0, aluAdd,  0,  1,  0,  10, 0,  1,   RW | AS, condAl, 1, 2'b00);
  addRow("read_x0",   0, aluAdd,  15, 0,  0,  0,  0,  2,   RW | AS, condAl, 1, 2'b00);
  addRow("beq_t",     0, aluSub,  0,  1,  1,  10, 10, 'h40, BR, condAl, 0, 2'b01);
  addRow("bne_t",     0, aluSub,  0,  1,  2,  10, 3,  'h20, BR | BN, condAl, 0, 2'b01);
  addRow("blt_t",     0, aluSlt,  0,  2,  1,  3,  10, -8,  BR, condAl, 0, 2'b01);
  addRow("beq_nt",    0, aluSub,  0,  1,  2,  10, 3,  'h10, BR, condAl, 0, 2'b00);
  addRow("jalr",      0, aluAdd,  16, 1,  0,  10, 0,  8,   RW | AS | BR | JL, condAl, 1, 2'b01);
  addRow("store",     0, aluAdd,  0,  2,  1,  3,  10, 4,   AS | MW, condAl, 0, 2'b00);
  addRow("arm_subs",  1, aluSub,  17, 1,  1,  10, 10, 0,   RW | FS, condAl, 1, 2'b00);
  addRow("arm_addeq", 1, aluAdd,  18, 1,  2,  10, 3,  0,   RW, condEq, 1, 2'b00);
  addRow("arm_addne", 1, aluAdd,  19, 1,  2,  10, 3,  0,   RW, condNe, 0, 2'b00);
  addRow("arm_subsne", 1, aluSub, 23, 1,  2,  10, 3,  0,   RW | FS, condNe, 0, 2'b00);
  addRow("arm_eq2",   1, aluAdd,  24, 1,  2,  10, 3,  0,   RW, condEq, 1, 2'b00);
  addRow("rand_add",  0, aluAdd,  25, 20, 21, 0,  0,  0,   RW | RN, condAl, 1, 2'b00);
  addRow("rand_sub",  0, aluSub,  26, 20, 21, 0,  0,  0,   RW | RN, condAl, 1, 2'b00);
  addRow("rand_slt",  0, aluSlt,  27, 20, 21, 0,  0,  0,   RW | RN, condAl, 1, 2'b00);
  addRow("rand_sra",  0, aluSra,  28, 20, 21, 0,  0,  0,   RW | RN, condAl, 1, 2'b00);
endtask

`endif

// File: dv/execTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "exec_cfg.svh"

module execTb
  import execPkg::*;
();

  // Control flag bits of a row
  localparam int AS = 1, RW = 2, MW = 4, BR = 8, BN = 16, FS = 32, JL = 64, FL = 128, RN = 256;

  typedef struct {
    string      name;
    bit         arm;
    aluOpT      op;
    logic [4:0] rd, rs1, rs2;
    logic [31:0] rd1, rd2, imm;
    int         ctl;
    condT       cond;
    bit         expWr;
    logic [1:0] expTaken;
  } rowT;

  logic clk, arstN, flushE;
  logic [31:0] rd1D, rd2D, immExtD, pcD, pcPlus4D;
  logic [4:0] rdD, rs1D, rs2D, rdW;
  logic armD, regWriteD, memWriteD, aluSrcD, pcSrcD, memSignedD;
  logic [1:0] branchD, flagWriteD, memSizeD, branchTakenE;
  aluOpT aluControlD;
  condT condD;
  resultSrcT resultSrcD;
  logic [31:0] pcTargetE, writeDataE, resultW;
  logic memWriteE, regWriteW;

  rowT rows[$];
  logic [31:0] archRegs[32];  // Architectural register model in program order
  bit archValid[32];
  logic [31:0] expRes[64], expTgt[64];
  logic [31:0] expWd[64];  // Store data after forwarding
  bit expMem[64];
  int rowErr[64];
  int errors = 0, checks = 0, cycles = 0;

  execTop DUT (.*);

  function automatic void addRow(string name, bit arm, aluOpT op, logic [4:0] rd, rs1, rs2,
                                 logic [31:0] rd1, rd2, imm, int ctl, condT cond,
                                 bit expWr, logic [1:0] expTaken);
    rowT r;
    r = '{name, arm, op, rd, rs1, rs2, rd1, rd2, imm, ctl, cond, expWr, expTaken};
    rows.push_back(r);
  endfunction

  `include "execTbVectors.svh"

  function automatic logic [31:0] aluRef(aluOpT op, logic [31:0] a, logic [31:0] b);
    case (op)
      aluAdd:  return a + b;
      aluSub:  return a - b;
      aluAnd:  return a & b;
      aluOr:   return a | b;
      aluXor:  return a ^ b;
      aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      aluSltu: return (a < b) ? 32'd1 : 32'd0;
      aluSll:  return a << b[4:0];
      aluSrl:  return a >> b[4:0];
      default: return $unsigned($signed(a) >>> b[4:0]);  // Arithmetic shift
    endcase
  endfunction

  task automatic compareField(int idx, string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("error %s %s expected %h actual %h", rows[idx].name, what, exp, act);
      errors++;
      rowErr[idx]++;
    end
  endtask

  task automatic idleInputs();
    {rd1D, rd2D, immExtD, pcD, pcPlus4D} = '0;
    {rdD, rs1D, rs2D} = '0;
    {armD, regWriteD, memWriteD, aluSrcD, pcSrcD, memSignedD, flushE} = '0;
    {branchD, flagWriteD, memSizeD} = '0;
    aluControlD = aluAdd;
    condD = condAl;
    resultSrcD = resAlu;
  endtask

  task automatic issueRow(int i);
    rowT r;
    logic [31:0] a, b, pc;
    r = rows[i];
    if (r.ctl & RN) begin
      r.rd1 = $urandom;
      r.rd2 = $urandom;
    end
    pc = 32'h100 + 4 * i;
    a = (r.rs1 != 0 && archValid[r.rs1]) ? archRegs[r.rs1] : r.rd1;
    b = (r.rs2 != 0 && archValid[r.rs2]) ? archRegs[r.rs2] : r.rd2;
    expRes[i] = (r.ctl & JL) ? pc + 4 : aluRef(r.op, a, (r.ctl & AS) ? r.imm : b);
    expTgt[i] = ((r.ctl & JL) ? a : pc) + r.imm;  // Register base only for jumps
    expWd[i] = b;
    expMem[i] = (r.ctl & MW) && !(r.ctl & FL);
    if (r.expWr && r.rd != 0) begin
      archRegs[r.rd] = expRes[i];
      archValid[r.rd] = 1'b1;
    end
    {rd1D, rd2D, immExtD, pcD, pcPlus4D} = {r.rd1, r.rd2, r.imm, pc, pc + 32'd4};
    {rdD, rs1D, rs2D, armD} = {r.rd, r.rs1, r.rs2, r.arm};
    regWriteD = (r.ctl & RW) != 0;
    memWriteD = (r.ctl & MW) != 0;
    aluSrcD = (r.ctl & AS) != 0;
    branchD = {(r.ctl & BN) != 0, (r.ctl & BR) != 0};
    flagWriteD = (r.ctl & FS) ? 2'b11 : 2'b00;
    flushE = (r.ctl & FL) != 0;
    resultSrcD = (r.ctl & JL) ? resPc4 : resAlu;
    aluControlD = r.op;
    condD = r.cond;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > rows.size() + 3 + 10 + 4) begin
      $display("timeout: run did not finish after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h150d_6c1a));
    loadRows();
    idleInputs();
    arstN = 1'b0;
    repeat (4) @(posedge clk);
    #5 arstN = 1'b1;
    for (int cyc = 0; cyc < rows.size() + 3; cyc++) begin
      @(posedge clk);
      #5;
      if (cyc < rows.size()) issueRow(cyc);
      else idleInputs();
      @(negedge clk);
      if (cyc >= 1 && cyc - 1 < rows.size()) begin  // Row now in execute
        compareField(cyc - 1, "branchTakenE", 32'(rows[cyc - 1].expTaken),
                     32'(branchTakenE));
        if (rows[cyc - 1].ctl & BR) begin
          compareField(cyc - 1, "pcTargetE", expTgt[cyc - 1], pcTargetE);
        end
        compareField(cyc - 1, "memWriteE", 32'(expMem[cyc - 1]), 32'(memWriteE));
        compareField(cyc - 1, "writeDataE", expWd[cyc - 1], writeDataE);
      end
      if (cyc >= 3) begin  // Row now in writeback
        compareField(cyc - 3, "regWriteW", 32'(rows[cyc - 3].expWr), 32'(regWriteW));
        if (rows[cyc - 3].expWr) begin
          compareField(cyc - 3, "resultW", expRes[cyc - 3], resultW);
          compareField(cyc - 3, "rdW", 32'(rows[cyc - 3].rd), 32'(rdW));
        end
        $display("%s: %s", rows[cyc - 3].name, rowErr[cyc - 3] ? "FAIL" : "ok");
      end
    end
    $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
+incdir+dv
hw/execPkg.sv
hw/execAlu.sv
hw/execCondLogic.sv
hw/execOperandSelect.sv
hw/execStage.sv
hw/execHazardUnit.sv
hw/execRetirePipe.sv
hw/execTop.sv
dv/execTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module execTb -o execTb \
  > build.log 2>&1 && ./obj_dir/execTb > sim.log 2>&1 || { echo "build or run error"; exit 1; }
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
